/* alu_unit.sv */
`timescale 1ns/1ps
`include "ooo_params.svh"

module alu_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue,
    input  ooo_pkg::alu_payload_t payload,
    input  logic [`OOO_XLEN-1:0]  op_a,
    input  logic [`OOO_XLEN-1:0]  op_b,
    output ooo_pkg::cdb_t         cdb
);
    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0] b;
    logic [`OOO_XLEN-1:0] res;

    assign b = payload.use_imm ? payload.imm : op_b;

    always_comb begin
        case (payload.op)
            OP_ADD:  res = op_a + b;
            OP_SUB:  res = op_a - b;
            OP_OR:   res = op_a | b;
            OP_XOR:  res = op_a ^ b;
            OP_SLL:  res = op_a << b[4:0];
            OP_SRL:  res = op_a >> b[4:0];
            OP_SLT:  res = {{(`OOO_XLEN-1){1'b0}}, $signed(op_a) < $signed(b)};
            default: res = op_a & b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) cdb <= '0;
        else cdb <= '{valid: issue, tag: payload.dst, rob_idx: payload.rob_idx, data: res};
    end

endmodule

/* flist.f */
+incdir+.
ooo_pkg.sv
rename_dispatch.sv
phys_reg_file.sv
reservation_station.sv
alu_unit.sv
mul_unit.sv
reorder_buffer.sv
ooo_core_top.sv
tb_ooo_core.sv

/* mul_unit.sv */
`timescale 1ns/1ps
`include "ooo_params.svh"

module mul_unit #(
    parameter int STAGES = `OOO_MUL_STAGES
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue,
    input  ooo_pkg::mul_payload_t payload,
    input  logic [`OOO_XLEN-1:0]  op_a,
    input  logic [`OOO_XLEN-1:0]  op_b,
    output ooo_pkg::cdb_t         cdb
);
    import ooo_pkg::*;

    cdb_t                 pipe_q [STAGES];
    logic [`OOO_XLEN-1:0] prod;

    assign prod = op_a * op_b;  // low half only

    // one op per cycle, STAGES in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= '{valid: issue, tag: payload.dst, rob_idx: payload.rob_idx, data: prod};
            for (int i = 1; i < STAGES; i++) begin
                pipe_q[i] <= pipe_q[i - 1];
            end
        end
    end

    assign cdb = pipe_q[STAGES - 1];

endmodule

/* ooo_core_top.sv */
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             issue_valid,
    input  logic [31:0]      instr,
    output logic             issue_full,
    output ooo_pkg::commit_t commit
);
    logic                             rob_full;
    logic                             alu_rs_full;
    logic                             mul_rs_full;
    logic                             free_valid;
    logic                             alloc_valid;
    logic                             alu_dispatch;
    logic                             mul_dispatch;
    logic                             alu_issue;
    logic                             mul_issue;
    logic [1:0]                       look_valid;
    logic [1:0]                       src_ready;
    logic [3:0][`OOO_XLEN-1:0]        rd_data;
    ooo_pkg::preg_t                   free_tag;
    ooo_pkg::preg_t [1:0]             look_tag;
    ooo_pkg::rob_idx_t                rob_tail;
    ooo_pkg::rob_alloc_t              rob_alloc;
    ooo_pkg::alu_payload_t            alu_payload;
    ooo_pkg::alu_payload_t            alu_issue_pl;
    ooo_pkg::mul_payload_t            mul_payload;
    ooo_pkg::mul_payload_t            mul_issue_pl;
    ooo_pkg::cdb_t                    alu_cdb;
    ooo_pkg::cdb_t                    mul_cdb;

    rename_dispatch u_rename (
        .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .instr(instr),
        .issue_full(issue_full), .rob_full(rob_full), .alu_rs_full(alu_rs_full),
        .mul_rs_full(mul_rs_full), .free_valid(free_valid), .free_tag(free_tag),
        .rob_alloc(rob_alloc), .alloc_valid(alloc_valid), .rob_tail(rob_tail),
        .look_tag(look_tag), .look_valid(look_valid), .src_ready(src_ready),
        .alu_dispatch(alu_dispatch), .mul_dispatch(mul_dispatch),
        .alu_payload(alu_payload), .mul_payload(mul_payload)
    );

    // read ports 0,1 feed the ALU, 2,3 the multiplier
    phys_reg_file u_prf (
        .clk(clk), .arst_n(arst_n), .alloc_valid(alloc_valid), .alloc_tag(rob_alloc.new_tag),
        .alu_cdb(alu_cdb), .mul_cdb(mul_cdb),
        .rd_tag({mul_issue_pl.src2, mul_issue_pl.src1, alu_issue_pl.src2, alu_issue_pl.src1}),
        .rd_data(rd_data), .look_tag(look_tag), .look_valid(look_valid)
    );

    reservation_station #(.payload_t(ooo_pkg::alu_payload_t), .DEPTH(`OOO_RS_DEPTH)) u_alu_rs (
        .clk(clk), .arst_n(arst_n), .dispatch(alu_dispatch), .payload(alu_payload),
        .src_ready(src_ready), .alu_cdb(alu_cdb), .mul_cdb(mul_cdb), .full(alu_rs_full),
        .issue(alu_issue), .issue_payload(alu_issue_pl)
    );

    reservation_station #(.payload_t(ooo_pkg::mul_payload_t), .DEPTH(`OOO_RS_DEPTH)) u_mul_rs (
        .clk(clk), .arst_n(arst_n), .dispatch(mul_dispatch), .payload(mul_payload),
        .src_ready(src_ready), .alu_cdb(alu_cdb), .mul_cdb(mul_cdb), .full(mul_rs_full),
        .issue(mul_issue), .issue_payload(mul_issue_pl)
    );

    alu_unit u_alu (
        .clk(clk), .arst_n(arst_n), .issue(alu_issue), .payload(alu_issue_pl),
        .op_a(rd_data[0]), .op_b(rd_data[1]), .cdb(alu_cdb)
    );

    mul_unit #(.STAGES(`OOO_MUL_STAGES)) u_mul (
        .clk(clk), .arst_n(arst_n), .issue(mul_issue), .payload(mul_issue_pl),
        .op_a(rd_data[2]), .op_b(rd_data[3]), .cdb(mul_cdb)
    );

    reorder_buffer u_rob (
        .clk(clk), .arst_n(arst_n), .alloc_valid(alloc_valid), .rob_alloc(rob_alloc),
        .tail(rob_tail), .full(rob_full), .alu_cdb(alu_cdb), .mul_cdb(mul_cdb),
        .commit(commit), .free_valid(free_valid), .free_tag(free_tag)
    );

    // the source holds off while full
    assert property (@(posedge clk) disable iff (!arst_n) issue_full |-> !issue_valid);

endmodule

/* ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath and register counts
`define OOO_XLEN        32
`define OOO_ARCH_REGS   32
`define OOO_PHYS_REGS   48
`define OOO_PREG_W      6

// queue sizes
`define OOO_ROB_DEPTH   8
`define OOO_ROB_IDX_W   3
`define OOO_RS_DEPTH    4
`define OOO_MUL_STAGES  3

`endif

/* ooo_pkg.sv */
`include "ooo_params.svh"

package ooo_pkg;

    typedef logic [`OOO_PREG_W-1:0]    preg_t;
    typedef logic [`OOO_ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [4:0]                areg_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_XOR, OP_SLL, OP_SRL, OP_SLT
    } alu_op_e;

    // one result bus
    typedef struct packed {
        logic                 valid;
        preg_t                tag;
        rob_idx_t             rob_idx;
        logic [`OOO_XLEN-1:0] data;
    } cdb_t;

    // src1/src2 names are shared by both station payloads
    typedef struct packed {
        alu_op_e              op;
        preg_t                src1;
        preg_t                src2;
        logic                 use_imm;
        logic [`OOO_XLEN-1:0] imm;
        preg_t                dst;
        rob_idx_t             rob_idx;
    } alu_payload_t;

    typedef struct packed {
        preg_t    src1;
        preg_t    src2;
        preg_t    dst;
        rob_idx_t rob_idx;
    } mul_payload_t;

    typedef struct packed {
        areg_t rd;
        logic  wen;
        preg_t new_tag;
        preg_t old_tag;  // returned to free list at retire
    } rob_alloc_t;

    typedef struct packed {
        logic                 valid;
        areg_t                rd;
        logic                 wen;
        logic [`OOO_XLEN-1:0] data;
    } commit_t;

endpackage

/* phys_reg_file.sv */
`timescale 1ns/1ps
`include "ooo_params.svh"

module phys_reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           alloc_valid,
    input  ooo_pkg::preg_t                 alloc_tag,
    input  ooo_pkg::cdb_t                  alu_cdb,
    input  ooo_pkg::cdb_t                  mul_cdb,
    input  ooo_pkg::preg_t [3:0]           rd_tag,
    output logic [3:0][`OOO_XLEN-1:0]      rd_data,
    input  ooo_pkg::preg_t [1:0]           look_tag,
    output logic [1:0]                     look_valid
);
    import ooo_pkg::*;

    localparam int NREG = `OOO_PHYS_REGS;

    logic [`OOO_XLEN-1:0] data_q [NREG];
    logic [NREG-1:0]      valid_q;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_data[i] = data_q[rd_tag[i]];
        end
        // same-cycle bus result counts as valid
        for (int i = 0; i < 2; i++) begin
            look_valid[i] = valid_q[look_tag[i]]
                || (alu_cdb.valid && alu_cdb.tag == look_tag[i])
                || (mul_cdb.valid && mul_cdb.tag == look_tag[i]);
        end
    end

    // tag 0 is x0, held at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NREG; i++) begin
                data_q[i]  <= '0;
                valid_q[i] <= i < `OOO_ARCH_REGS;
            end
        end else begin
            if (alloc_valid && alloc_tag != '0) valid_q[alloc_tag] <= 1'b0;
            if (alu_cdb.valid && alu_cdb.tag != '0) begin
                data_q[alu_cdb.tag]  <= alu_cdb.data;
                valid_q[alu_cdb.tag] <= 1'b1;
            end
            if (mul_cdb.valid && mul_cdb.tag != '0) begin
                data_q[mul_cdb.tag]  <= mul_cdb.data;
                valid_q[mul_cdb.tag] <= 1'b1;
            end
        end
    end

endmodule

/* rename_dispatch.sv */
`timescale 1ns/1ps
`include "ooo_params.svh"

module rename_dispatch (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  issue_valid,
    input  logic [31:0]           instr,
    output logic                  issue_full,
    input  logic                  rob_full,
    input  logic                  alu_rs_full,
    input  logic                  mul_rs_full,
    input  logic                  free_valid,
    input  ooo_pkg::preg_t        free_tag,
    output ooo_pkg::rob_alloc_t   rob_alloc,
    output logic                  alloc_valid,
    input  ooo_pkg::rob_idx_t     rob_tail,
    output ooo_pkg::preg_t [1:0]  look_tag,
    input  logic [1:0]            look_valid,
    output logic [1:0]            src_ready,
    output logic                  alu_dispatch,
    output logic                  mul_dispatch,
    output ooo_pkg::alu_payload_t alu_payload,
    output ooo_pkg::mul_payload_t mul_payload
);
    import ooo_pkg::*;

    localparam int FL_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    preg_t               rat_q [`OOO_ARCH_REGS];
    preg_t               fl_q [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_rd_q;
    logic [FL_PTR_W-1:0] fl_wr_q;
    logic [FL_PTR_W:0]   fl_cnt_q;

    areg_t   rs1;
    areg_t   rs2;
    areg_t   rd;
    logic    is_r;
    logic    is_i;
    logic    is_mul;
    logic    wen;
    logic    accept;
    logic    pop;
    alu_op_e op;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign is_r   = instr[6:0] == 7'b0110011;
    assign is_i   = instr[6:0] == 7'b0010011;
    assign is_mul = is_r && instr[31:25] == 7'b0000001;

    always_comb begin
        case (instr[14:12])
            3'b000:  op = (is_r && instr[30]) ? OP_SUB : OP_ADD;
            3'b001:  op = OP_SLL;
            3'b010:  op = OP_SLT;
            3'b100:  op = OP_XOR;
            3'b101:  op = OP_SRL;
            3'b110:  op = OP_OR;
            default: op = OP_AND;
        endcase
    end

    assign issue_full = rob_full || fl_cnt_q == '0 || (is_mul ? mul_rs_full : alu_rs_full);
    assign accept     = issue_valid && !issue_full;
    assign wen        = rd != 5'd0;  // x0 never gets a new tag
    assign pop        = accept && wen;

    assign look_tag[0] = rat_q[rs1];
    assign look_tag[1] = rat_q[rs2];
    assign src_ready   = {is_i | look_valid[1], look_valid[0]};

    assign alloc_valid  = accept;
    assign rob_alloc    = '{rd: rd, wen: wen, new_tag: wen ? fl_q[fl_rd_q] : '0,
                            old_tag: rat_q[rd]};
    assign alu_dispatch = accept && !is_mul;
    assign mul_dispatch = accept && is_mul;

    assign alu_payload = '{op: op, src1: look_tag[0], src2: look_tag[1], use_imm: is_i,
                           imm: {{20{instr[31]}}, instr[31:20]},
                           dst: rob_alloc.new_tag, rob_idx: rob_tail};
    assign mul_payload = '{src1: look_tag[0], src2: look_tag[1],
                           dst: rob_alloc.new_tag, rob_idx: rob_tail};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                rat_q[i] <= preg_t'(i);  // identity map
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_q[i] <= preg_t'(`OOO_ARCH_REGS + i);
            end
            fl_rd_q  <= '0;
            fl_wr_q  <= '0;
            fl_cnt_q <= (FL_PTR_W+1)'(FL_DEPTH);
        end else begin
            if (pop) begin
                rat_q[rd] <= fl_q[fl_rd_q];
                fl_rd_q   <= fl_rd_q + 1'b1;
            end
            if (free_valid) begin
                fl_q[fl_wr_q] <= free_tag;
                fl_wr_q       <= fl_wr_q + 1'b1;
            end
            fl_cnt_q <= fl_cnt_q + (FL_PTR_W+1)'(free_valid) - (FL_PTR_W+1)'(pop);
        end
    end

    // more tags returned than were ever handed out
    assert property (@(posedge clk) disable iff (!arst_n)
        free_valid && !pop |-> fl_cnt_q < (FL_PTR_W+1)'(FL_DEPTH));

endmodule

/* reorder_buffer.sv */
`timescale 1ns/1ps
`include "ooo_params.svh"

module reorder_buffer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                alloc_valid,
    input  ooo_pkg::rob_alloc_t rob_alloc,
    output ooo_pkg::rob_idx_t   tail,
    output logic                full,
    input  ooo_pkg::cdb_t       alu_cdb,
    input  ooo_pkg::cdb_t       mul_cdb,
    output ooo_pkg::commit_t    commit,
    output logic                free_valid,
    output ooo_pkg::preg_t      free_tag
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;

    rob_alloc_t           info_q [DEPTH];
    logic [`OOO_XLEN-1:0] data_q [DEPTH];
    logic [DEPTH-1:0]     busy_q;
    logic [DEPTH-1:0]     done_q;
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic                 retire;

    assign retire = busy_q[head_q] && done_q[head_q];
    assign full   = &busy_q;  // entries are contiguous from head
    assign tail   = tail_q;

    assign commit = '{valid: retire, rd: info_q[head_q].rd, wen: info_q[head_q].wen,
                      data: data_q[head_q]};
    assign free_valid = retire && info_q[head_q].wen;
    assign free_tag   = info_q[head_q].old_tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
            done_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (retire) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            if (alloc_valid) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (alu_cdb.valid) done_q[alu_cdb.rob_idx] <= 1'b1;
            if (mul_cdb.valid) done_q[mul_cdb.rob_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid)   info_q[tail_q]           <= rob_alloc;
        if (alu_cdb.valid) data_q[alu_cdb.rob_idx] <= alu_cdb.data;
        if (mul_cdb.valid) data_q[mul_cdb.rob_idx] <= mul_cdb.data;
    end

    // a result must land on a live entry that is still waiting
    assert property (@(posedge clk) disable iff (!arst_n)
        (alu_cdb.valid -> busy_q[alu_cdb.rob_idx] && !done_q[alu_cdb.rob_idx])
        && (mul_cdb.valid -> busy_q[mul_cdb.rob_idx] && !done_q[mul_cdb.rob_idx]));

endmodule

/* reservation_station.sv */
`timescale 1ns/1ps

module reservation_station #(
    parameter type payload_t = ooo_pkg::alu_payload_t,
    parameter int  DEPTH     = 4
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          dispatch,
    input  payload_t      payload,
    input  logic [1:0]    src_ready,
    input  ooo_pkg::cdb_t alu_cdb,
    input  ooo_pkg::cdb_t mul_cdb,
    output logic          full,
    output logic          issue,
    output payload_t      issue_payload
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    payload_t         ent_q [DEPTH];
    payload_t         ent_d [DEPTH];
    logic [1:0]       rdy_q [DEPTH];
    logic [1:0]       rdy_d [DEPTH];
    logic [DEPTH-1:0] vld_q;
    logic [DEPTH-1:0] vld_d;
    logic [IDX_W-1:0] sel;

    function automatic logic woken(input preg_t tag, input cdb_t a, input cdb_t b);
        return (a.valid && a.tag == tag) || (b.valid && b.tag == tag);
    endfunction

    // slot 0 is the oldest, so the lowest ready slot wins
    always_comb begin
        issue = 1'b0;
        sel   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (vld_q[i] && &rdy_q[i]) begin
                issue = 1'b1;
                sel   = IDX_W'(i);
            end
        end
    end

    assign issue_payload = ent_q[sel];
    assign full          = &vld_q;

    always_comb begin
        logic placed;
        placed = 1'b0;
        vld_d  = vld_q;
        ent_d  = ent_q;
        for (int i = 0; i < DEPTH; i++) begin
            rdy_d[i] = rdy_q[i] | {woken(ent_q[i].src2, alu_cdb, mul_cdb),
                                   woken(ent_q[i].src1, alu_cdb, mul_cdb)};
        end
        if (issue) begin  // close the gap left by the issued entry
            for (int i = 0; i < DEPTH - 1; i++) begin
                if (i >= int'(sel)) begin
                    ent_d[i] = ent_d[i + 1];
                    rdy_d[i] = rdy_d[i + 1];
                    vld_d[i] = vld_d[i + 1];
                end
            end
            vld_d[DEPTH - 1] = 1'b0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (dispatch && !placed && !vld_d[i]) begin
                ent_d[i] = payload;
                rdy_d[i] = src_ready;
                vld_d[i] = 1'b1;
                placed   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) vld_q <= '0;
        else         vld_q <= vld_d;
    end

    always_ff @(posedge clk) begin
        ent_q <= ent_d;
        rdy_q <= rdy_d;
    end

    // rename must see the full level before it dispatches
    assert property (@(posedge clk) disable iff (!arst_n) dispatch |-> !full);

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_ooo_core -f flist.f -o sim_ooo

./obj_dir/sim_ooo | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

/* tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int N_INSTR     = 300;
    localparam int N_INIT      = 31;
    localparam int N_BURST     = 21;
    localparam int CYCLE_LIMIT = 20 * N_INSTR;

    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLL  = 5;
    localparam int K_SRL  = 6;
    localparam int K_SLT  = 7;
    localparam int K_ADDI = 8;
    localparam int K_ANDI = 9;
    localparam int K_ORI  = 10;
    localparam int K_XORI = 11;
    localparam int K_MUL  = 12;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        issue_valid;
    logic [31:0] instr;
    logic        issue_full;
    commit_t     commit;

    logic [31:0] lfsr_state;
    logic [31:0] gold [32];      // architectural state, program order
    commit_t     exp_mem [N_INSTR];
    commit_t     exp_head;
    int          n_pushed;
    int          n_popped;
    int          mismatches;
    int          other_errors;
    int          cycles = 0;
    logic        saw_full;

    ooo_core_top dut_i (
        .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .instr(instr),
        .issue_full(issue_full), .commit(commit)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        case (kind)
            K_AND, K_ANDI: f3 = 3'b111;
            K_OR, K_ORI:   f3 = 3'b110;
            K_XOR, K_XORI: f3 = 3'b100;
            K_SLL:         f3 = 3'b001;
            K_SRL:         f3 = 3'b101;
            K_SLT:         f3 = 3'b010;
            default:       f3 = 3'b000;  // add, sub, addi, mul
        endcase
        f7 = (kind == K_SUB) ? 7'b0100000 : (kind == K_MUL) ? 7'b0000001 : 7'b0;
        if (kind >= K_ADDI && kind <= K_XORI) begin
            return {imm, rs1, f3, rd, 7'b0010011};
        end
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] compute(input int kind, input logic [31:0] a,
                                            input logic [31:0] b, input logic [11:0] imm);
        logic [31:0] simm;
        logic [63:0] prod;
        simm = {{20{imm[11]}}, imm};
        prod = a * b;
        case (kind)
            K_ADD:   return a + b;
            K_SUB:   return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            K_SLL:   return a << b[4:0];
            K_SRL:   return a >> b[4:0];
            K_SLT:   return {31'b0, $signed(a) < $signed(b)};
            K_ADDI:  return a + simm;
            K_ANDI:  return a & simm;
            K_ORI:   return a | simm;
            K_XORI:  return a ^ simm;
            default: return prod[31:0];  // low half of the product
        endcase
    endfunction

    // present the word, wait for room, then raise valid for one accepting edge
    task automatic send(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] res;
        commit_t     exp;
        res = compute(kind, gold[rs1], gold[rs2], imm);
        exp = '{valid: 1'b1, rd: rd, wen: rd != 5'd0, data: res};
        instr       <= encode(kind, rd, rs1, rs2, imm);
        issue_valid <= 1'b0;
        @(posedge clk);
        while (issue_full) @(posedge clk);  // full only drops without an accept
        issue_valid <= 1'b1;
        @(posedge clk);
        issue_valid       <= 1'b0;
        exp_mem[n_pushed] <= exp;
        n_pushed          <= n_pushed + 1;
        if (rd != 5'd0) gold[rd] = res;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_random();
        int         kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        kind = int'(rand_bits(4));
        if (kind > K_MUL) kind = K_MUL;
        // small pool most of the time for tight reuse
        rd  = rand_bits(1) ? 5'(rand_bits(3)) : 5'(rand_bits(5));
        rs1 = rand_bits(1) ? 5'(rand_bits(3)) : 5'(rand_bits(5));
        rs2 = rand_bits(1) ? 5'(rand_bits(3)) : 5'(rand_bits(5));
        send(kind, rd, rs1, rs2, 12'(rand_bits(12)));
        if (rand_bits(2) == 0) idle(int'(rand_bits(2)));
    endtask

    assign exp_head = exp_mem[n_popped];

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) n_popped <= 0;
        else if (commit.valid) n_popped <= n_popped + 1;
    end

    always @(posedge clk) begin
        if (arst_n && issue_full) saw_full <= 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d commits seen",
                     CYCLE_LIMIT, n_popped, N_INSTR);
            $display("TEST FAIL");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) commit.valid |-> n_popped < n_pushed)
        else begin
            other_errors++;
            $display("%0t: a commit came out with no instruction outstanding", $time);
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid |-> commit.rd == exp_head.rd && commit.wen == exp_head.wen
            && (!exp_head.wen || commit.data == exp_head.data))
        else begin
            mismatches++;
            $display("Mismatch at %0t: commit %0d rd x%0d wen %0b data %h, expected x%0d %0b %h",
                     $time, $sampled(n_popped), $sampled(commit.rd), $sampled(commit.wen),
                     $sampled(commit.data), $sampled(exp_head.rd), $sampled(exp_head.wen),
                     $sampled(exp_head.data));
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        n_pushed == 0 |-> !commit.valid && !issue_full)
        else begin
            other_errors++;
            $display("%0t: commit or issue_full was high after reset before any issue", $time);
        end

    initial begin
        arst_n       = 1'b0;
        issue_valid  = 1'b0;
        instr        = '0;
        lfsr_state   = 32'he69c;
        n_pushed     = 0;
        mismatches   = 0;
        other_errors = 0;
        saw_full     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            gold[i] = '0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        idle(3);

        // load every register through x0
        for (int i = 1; i <= N_INIT; i++) begin
            send(K_ADDI, 5'(i), 5'd0, 5'd0, 12'(rand_bits(12)));
        end

        // dependent MUL chain on x5, no gaps
        for (int i = 0; i < N_BURST - 1; i++) begin
            send(K_MUL, 5'd5, 5'd5, 5'(2 * rand_bits(2) + 1), 12'd0);
        end
        send(K_ADD, 5'd6, 5'd5, 5'd5, 12'd0);

        repeat (N_INSTR - N_INIT - N_BURST) send_random();

        while (n_popped != N_INSTR) @(posedge clk);
        idle(10);  // window for stray commits

        if (n_pushed != n_popped) begin
            other_errors++;
            $display("%0d instructions issued but %0d committed", n_pushed, n_popped);
        end
        if (!saw_full) begin
            other_errors++;
            $display("issue_full never went high during the run");
        end
        $display("mismatches %0d, other errors %0d, commits %0d",
                 mismatches, other_errors, n_popped);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
